//--- dv/rv_decode_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage_checker (
    input logic                    g_clk,
    input logic                    g_resetn,
    input logic                    s1_bubble_i,
    input logic                    s1_busy_o,
    input logic                    s1_flush_i,
    input logic                    s2_busy_i,
    input logic                    s2_valid_o,
    input rv_decode_pkg::dec_out_t s2_out_o
);
    import rv_decode_pkg::*;

    int unsigned fail_count = 0;    // Assertion failures so far

    // --------------------
    // Stage properties
    // --------------------

    a_reset_clears: assert property (@(posedge g_clk) !g_resetn |=> !s2_valid_o)
        else begin
            $error("s2_valid_o high in the cycle after reset");
            fail_count++;
        end

    a_hold_on_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_busy_i && !s1_flush_i |=> $stable(s2_valid_o) && $stable(s2_out_o))
        else begin
            $error("Output item changed while downstream busy");
            fail_count++;
        end

    a_trap_no_fu: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_out_o.trap |-> s2_out_o.fu == FU_NONE)
        else begin
            $error("Trapping item carries a functional unit");
            fail_count++;
        end

    a_bubble_busy: assert property (@(posedge g_clk) s1_bubble_i |-> s1_busy_o)
        else begin
            $error("Bubble request without s1_busy_o");
            fail_count++;
        end

endmodule

bind rv_decode_stage rv_decode_stage_checker u_checker (.*);

`default_nettype wire

//--- dv/rv_decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_decode_stage_tb;
    import rv_decode_pkg::*;

    localparam int          TIMEOUT = 64;              // Cycles per acceptance wait
    localparam logic [31:0] TARGET  = 32'h0000_4000;   // Redirect target

    // Source flags: a_rs1 a_pcim b_rs2 b_imm c_rs2 c_pcim rd_none
    localparam logic [6:0] S_NONE  = 7'b0000000;
    localparam logic [6:0] S_RR    = 7'b1010000;
    localparam logic [6:0] S_RI    = 7'b1001000;
    localparam logic [6:0] S_LUI   = 7'b0001000;
    localparam logic [6:0] S_AUIPC = 7'b0100000;
    localparam logic [6:0] S_ST    = 7'b1001101;
    localparam logic [6:0] S_BR    = 7'b1010011;
    localparam logic [6:0] S_JAL   = 7'b0000010;

    // Load/store micro-ops as {load, store, width, signed}
    localparam logic [4:0] U_LB  = {2'b10, LSU_BYTE, 1'b1};
    localparam logic [4:0] U_LHU = {2'b10, LSU_HALF, 1'b0};
    localparam logic [4:0] U_LW  = {2'b10, LSU_WORD, 1'b1};
    localparam logic [4:0] U_SB  = {2'b01, LSU_BYTE, 1'b0};
    localparam logic [4:0] U_SW  = {2'b01, LSU_WORD, 1'b0};

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        err;           // Fetch error flag
        logic [2:0]  fu;
        logic [4:0]  uop;
        logic [4:0]  rd;
        opr_src_t    src;
        imm_fmt_e    fmt;
        logic        redir;         // Redirect PC before this entry
    } vec_t;

    logic        g_clk;
    logic        g_resetn;
    logic        s1_valid_i;
    logic        s1_busy_o;
    logic [31:0] s1_data_i;
    logic        s1_error_i;
    logic        s1_flush_i;
    logic        s1_bubble_i;
    logic [4:0]  s1_rs1_addr_o;
    logic [4:0]  s1_rs2_addr_o;
    logic [31:0] s1_rs1_rdata_i;
    logic [31:0] s1_rs2_rdata_i;
    logic        cf_req_i;
    logic [31:0] cf_target_i;
    logic        cf_ack_i;
    logic        s2_valid_o;
    logic        s2_busy_i;
    dec_out_t    s2_out_o;

    vec_t        table_q[$];
    logic [31:0] pc_model;
    logic [31:0] lfsr;
    logic        bp_on;             // Random back-pressure enabled
    int          n_seen;            // Items taken by downstream

    rv_decode_stage dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // Count non-bubble items handed downstream
    always @(posedge g_clk) begin
        if (g_resetn && s2_valid_o && !s2_busy_i && s2_out_o.instr != 32'h0) begin
            n_seen++;
        end
    end

    // Stop at the first protocol violation of the bound checker
    always @(dut.u_checker.fail_count) begin
        if (dut.u_checker.fail_count != 0) begin
            $display("Protocol checker flagged an assertion failure at time %0t", $time);
            stop_on_error();
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // Taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] w, input imm_fmt_e fmt);
        case (fmt)
            IMM_I:     return {{20{w[31]}}, w[31:20]};
            IMM_S:     return {{20{w[31]}}, w[31:25], w[11:7]};
            IMM_B:     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:     return {w[31:12], 12'h000};
            IMM_J:     return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            IMM_SHAMT: return {27'h0, w[24:20]};
            default:   return 32'h0;
        endcase
    endfunction

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic add_entry(input logic [31:0] word, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic err,
                             input logic [2:0] fu, input logic [4:0] uop,
                             input logic [4:0] rd, input logic [6:0] src,
                             input imm_fmt_e fmt, input logic redir);
        vec_t v;
        v = {word, rs1, rs2, err, fu, uop, rd, src, fmt, redir};
        table_q.push_back(v);
    endtask

    task automatic build_table();
        add_entry(32'h002081b3, 'h7fff0001, 'h00001234, 0, FU_ALU, ALU_ADD,  3, S_RR, IMM_NONE, 0);
        add_entry(32'h407302b3, 'h00000050, 'h00000007, 0, FU_ALU, ALU_SUB,  5, S_RR, IMM_NONE, 0);
        add_entry(32'h4020d233, 'h80000000, 'h00000004, 0, FU_ALU, ALU_SRA,  4, S_RR, IMM_NONE, 0);
        add_entry(32'h0020b333, 'h00000001, 'hffffffff, 0, FU_ALU, ALU_SLTU, 6, S_RR, IMM_NONE, 0);
        add_entry(32'hffb10093, 'h00000100, 'h0badf00d, 0, FU_ALU, ALU_ADD,  1, S_RI, IMM_I, 0);
        add_entry(32'h12344393, 'h0000ffff, 'h0badf00d, 0, FU_ALU, ALU_XOR,  7, S_RI, IMM_I, 0);
        add_entry(32'h40755493, 'hf0000000, 'h0badf00d, 0, FU_ALU, ALU_SRA,  9, S_RI, IMM_SHAMT, 0);
        add_entry(32'h01f19113, 'h00000001, 'h0badf00d, 0, FU_ALU, ALU_SLL,  2, S_RI, IMM_SHAMT, 0);
        add_entry(32'habcde537, 'h11111111, 'h22222222, 0, FU_ALU, ALU_OR,  10, S_LUI, IMM_U, 0);
        add_entry(32'h12345597, 'h11111111, 'h22222222, 0, FU_ALU, ALU_ADD, 11, S_AUIPC, IMM_U, 0);
        add_entry(32'h00408603, 'h20000000, 'h33333333, 0, FU_LSU, U_LB,  12, S_RI, IMM_I, 0);
        add_entry(32'hffe15683, 'h20000010, 'h33333333, 0, FU_LSU, U_LHU, 13, S_RI, IMM_I, 0);
        add_entry(32'h0081a703, 'h20000020, 'h33333333, 0, FU_LSU, U_LW,  14, S_RI, IMM_I, 0);
        add_entry(32'h005301a3, 'h20000030, 'h000000a5, 0, FU_LSU, U_SB,   0, S_ST, IMM_S, 0);
        add_entry(32'hfe742a23, 'h20000040, 'hdeadbeef, 0, FU_LSU, U_SW,   0, S_ST, IMM_S, 0);
        add_entry(32'h00208863, 'h00000005, 'h00000005, 0, FU_CFU, CFU_BEQ,  0, S_BR, IMM_B, 0);
        add_entry(32'hfe41ece3, 'h00000003, 'h00000009, 0, FU_CFU, CFU_BLTU, 0, S_BR, IMM_B, 0);
        add_entry(32'h001000ef, 'h44444444, 'h55555555, 0, FU_CFU, CFU_JALI, 1, S_JAL, IMM_J, 1);
        add_entry(32'h010302e7, 'h30000000, 'h55555555, 0, FU_CFU, CFU_JALR, 5, S_RI, IMM_I, 0);
        add_entry(32'h00000073, 'h66666666, 'h77777777, 0, FU_CFU, CFU_ECALL,  0, S_NONE, IMM_NONE, 0);
        add_entry(32'h00100073, 'h66666666, 'h77777777, 0, FU_CFU, CFU_EBREAK, 0, S_NONE, IMM_NONE, 0);
        add_entry(32'h30200073, 'h66666666, 'h77777777, 0, FU_CFU, CFU_MRET,   0, S_NONE, IMM_NONE, 0);
        add_entry(32'h00004501, 'h12121212, 'h34343434, 0, FU_NONE, 0, TRAP_IOPCODE, S_NONE, IMM_NONE, 0);
        add_entry(32'h300110f3, 'h12121212, 'h34343434, 0, FU_NONE, 0, TRAP_IOPCODE, S_NONE, IMM_NONE, 0);
        add_entry(32'h0000007f, 'h12121212, 'h34343434, 0, FU_NONE, 0, TRAP_IOPCODE, S_NONE, IMM_NONE, 0);
        add_entry(32'h002081b3, 'h0000aaaa, 'h0000bbbb, 1, FU_NONE, 0, TRAP_IACCESS, S_RR, IMM_NONE, 0);
        add_entry(32'h00001617, 'h88888888, 'h99999999, 0, FU_ALU, ALU_ADD, 12, S_AUIPC, IMM_U, 0);
    endtask

    task automatic drive_entry(input vec_t e);
        s1_valid_i     = 1'b1;
        s1_data_i      = e.word;
        s1_error_i     = e.err;
        s1_rs1_rdata_i = e.rs1;
        s1_rs2_rdata_i = e.rs2;
    endtask

    task automatic redirect(input logic [31:0] target);
        s1_valid_i  = 1'b0;
        s2_busy_i   = 1'b0;
        cf_req_i    = 1'b1;
        cf_ack_i    = 1'b1;
        cf_target_i = target;
        @(posedge g_clk);
        @(negedge g_clk);
        cf_req_i = 1'b0;
        cf_ack_i = 1'b0;
        pc_model = target;
    endtask

    // One bubble cycle with a word on the fetch side, then check the zeroed item
    task automatic insert_bubble(input vec_t e, input logic word_valid);
        drive_entry(e);
        s1_valid_i  = word_valid;
        s1_bubble_i = 1'b1;
        @(posedge g_clk);
        check_val("s1_busy_o", s1_busy_o, 1'b1);
        @(negedge g_clk);
        s1_bubble_i = 1'b0;
        check_val("s2_valid_o", s2_valid_o, 1'b1);
        check_val("s2_out_o.rd", s2_out_o.rd, 5'd0);
        check_val("s2_out_o.uop", s2_out_o.uop, 5'd0);
        check_val("s2_out_o.fu", s2_out_o.fu, 3'd0);
        check_val("s2_out_o.trap", s2_out_o.trap, 1'b0);
        check_val("s2_out_o.instr", s2_out_o.instr, 32'h0);
    endtask

    // Drive one entry, wait for acceptance, then check the registered item
    task automatic apply_entry(input vec_t e);
        logic [31:0] imm;
        logic [31:0] pcim;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        logic [31:0] exp_c;
        int          waited;
        logic        accepted;
        imm   = imm_of(e.word, e.fmt);
        pcim  = pc_model + imm;
        exp_a = e.src.a_rs1 ? e.rs1 : (e.src.a_pcim ? pcim : 32'h0);
        exp_b = e.src.b_rs2 ? e.rs2 : (e.src.b_imm ? imm : 32'h0);
        exp_c = e.src.c_rs2 ? e.rs2 : (e.src.c_pcim ? pcim : 32'h0);
        drive_entry(e);
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT) begin
            if (bp_on) begin
                lfsr      = lfsr_next(lfsr);
                s2_busy_i = lfsr[0];
            end else begin
                s2_busy_i = 1'b0;
            end
            @(posedge g_clk);
            accepted = !s1_busy_o;
            if (accepted) begin
                check_val("s1_rs1_addr_o", s1_rs1_addr_o, e.word[19:15]);
                check_val("s1_rs2_addr_o", s1_rs2_addr_o, e.word[24:20]);
            end
            @(negedge g_clk);
            waited++;
        end
        if (!accepted) begin
            $display("Timeout: word %h was not accepted within %0d cycles", e.word, TIMEOUT);
            stop_on_error();
        end
        pc_model = pc_model + 32'd4;
        check_val("s2_valid_o", s2_valid_o, 1'b1);
        check_val("s2_out_o.rd", s2_out_o.rd, e.rd);
        check_val("s2_out_o.opr_a", s2_out_o.opr_a, exp_a);
        check_val("s2_out_o.opr_b", s2_out_o.opr_b, exp_b);
        check_val("s2_out_o.opr_c", s2_out_o.opr_c, exp_c);
        check_val("s2_out_o.uop", s2_out_o.uop, e.uop);
        check_val("s2_out_o.fu", s2_out_o.fu, e.fu);
        check_val("s2_out_o.trap", s2_out_o.trap, e.fu == FU_NONE);
        check_val("s2_out_o.instr", s2_out_o.instr, e.word);
    endtask

    initial begin
        g_resetn       = 1'b0;
        s1_valid_i     = 1'b0;
        s1_data_i      = 32'h0;
        s1_error_i     = 1'b0;
        s1_flush_i     = 1'b0;
        s1_bubble_i    = 1'b0;
        s1_rs1_rdata_i = 32'h0;
        s1_rs2_rdata_i = 32'h0;
        cf_req_i       = 1'b0;
        cf_target_i    = 32'h0;
        cf_ack_i       = 1'b0;
        s2_busy_i      = 1'b0;
        pc_model       = `RV_PC_RESET;
        lfsr           = 32'hcea;
        bp_on          = 1'b0;
        n_seen         = 0;
        build_table();
        repeat (2) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        // --------------------
        // Table, then again under back-pressure
        // --------------------
        for (int pass = 0; pass < 2; pass++) begin
            bp_on = (pass == 1);
            foreach (table_q[i]) begin
                if (table_q[i].redir) begin
                    redirect(TARGET);
                end
                apply_entry(table_q[i]);
            end
            s1_valid_i = 1'b0;      // Let the last item drain
            s2_busy_i  = 1'b0;
            @(posedge g_clk);
            @(negedge g_clk);
        end
        bp_on = 1'b0;
        check_val("items consumed", n_seen, 2 * table_q.size());

        // --------------------
        // Flush and bubble
        // --------------------
        apply_entry(table_q[0]);
        s1_valid_i = 1'b0;
        s2_busy_i  = 1'b1;          // Item would be held without the flush
        s1_flush_i = 1'b1;
        @(posedge g_clk);
        @(negedge g_clk);
        s1_flush_i = 1'b0;
        s2_busy_i  = 1'b0;
        check_val("s2_valid_o", s2_valid_o, 1'b0);

        insert_bubble(table_q[25], 1'b1);   // Fetch error waits behind the bubble
        insert_bubble(table_q[17], 1'b0);   // Valid comes from the bubble alone
        apply_entry(table_q[17]);           // jal target shows the PC did not move

        s1_valid_i = 1'b0;
        @(posedge g_clk);
        @(negedge g_clk);
        if (dut.u_checker.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("Protocol checker saw %0d assertion failures", dut.u_checker.fail_count);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- rv_decode_stage.f
+incdir+src
src/rv_decode_pkg.sv
src/rv_instr_classify.sv
src/rv_imm_gen.sv
src/rv_operand_select.sv
src/rv_decode_pipereg.sv
src/rv_decode_stage.sv
dv/rv_decode_stage_checker.sv
dv/rv_decode_stage_tb.sv

//--- src/rv_decode_pipereg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_pipereg (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    valid_i,
    input  logic                    bubble_i,
    input  logic                    flush_i,
    input  rv_decode_pkg::dec_out_t data_i,
    input  logic                    busy_i,
    output logic                    valid_o,
    output rv_decode_pkg::dec_out_t data_o
);
    import rv_decode_pkg::*;

    logic     valid_q;
    dec_out_t data_q;
    dec_out_t n_data;               // Next item, bubble applied

    // Bubble keeps operands, clears everything that could have an effect
    always_comb begin
        n_data = data_i;
        if (bubble_i) begin
            n_data.rd    = '0;
            n_data.uop   = '0;
            n_data.fu    = FU_NONE;
            n_data.trap  = 1'b0;
            n_data.instr = '0;
        end
    end

    // --------------------
    // Stage register
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush_i) begin
            valid_q <= 1'b0;            // Flush beats a load
        end else if (!busy_i) begin
            valid_q <= valid_i || bubble_i;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!busy_i) begin
            data_q <= n_data;           // Held while downstream busy
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

//--- src/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_settings.svh"

package rv_decode_pkg;

    // --------------------
    // Functional units and micro-ops
    // --------------------

    typedef enum logic [2:0] {
        FU_NONE = 3'b000,
        FU_ALU  = 3'b001,           // Integer ALU
        FU_CFU  = 3'b010,           // Control flow
        FU_LSU  = 3'b100            // Load/store
    } fu_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SRA, ALU_SRL, ALU_SLL
    } alu_op_e;

    typedef enum logic [4:0] {
        CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU,
        CFU_JALI, CFU_JALR, CFU_ECALL, CFU_EBREAK, CFU_MRET
    } cfu_op_e;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'b01,
        LSU_HALF = 2'b10,
        LSU_WORD = 2'b11
    } lsu_width_e;

    typedef struct packed {
        logic       load;
        logic       store;
        lsu_width_e width;
        logic       is_signed;      // Sign-extend load data
    } lsu_uop_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_fmt_e;

    typedef enum logic [4:0] {
        TRAP_IACCESS = 5'd1,        // Fetch error
        TRAP_IOPCODE = 5'd2         // Illegal instruction
    } trap_cause_e;

    // --------------------
    // Decoder and stage results
    // --------------------

    typedef struct packed {
        logic a_rs1;
        logic a_pcim;
        logic b_rs2;
        logic b_imm;
        logic c_rs2;
        logic c_pcim;
        logic rd_none;              // No register writeback
    } opr_src_t;

    typedef struct packed {
        fu_e        fu;
        logic [4:0] uop;            // Bits of the unit's own op type
        imm_fmt_e   imm_fmt;
        opr_src_t   opr_src;
        logic       illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;  // Holds trap cause on a trap
        logic [`RV_XLEN-1:0]   opr_a;
        logic [`RV_XLEN-1:0]   opr_b;
        logic [`RV_XLEN-1:0]   opr_c;
        logic [4:0]            uop;
        fu_e                   fu;
        logic                  trap;
        logic [31:0]           instr;
    } dec_out_t;

endpackage

`default_nettype wire

//--- src/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// --------------------
// Core widths
// --------------------

`define RV_XLEN     32              // Data path width
`define RV_REG_AW   5               // Register file address width

// Fetch starts here
`define RV_PC_RESET 32'h8000_0000

`endif

//--- src/rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_decode_stage (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     s1_valid_i,     // Fetched word valid
    output logic                     s1_busy_o,
    input  logic [31:0]              s1_data_i,
    input  logic                     s1_error_i,     // Fetch error on this word
    input  logic                     s1_flush_i,
    input  logic                     s1_bubble_i,
    output logic [`RV_REG_AW-1:0]    s1_rs1_addr_o,
    output logic [`RV_REG_AW-1:0]    s1_rs2_addr_o,
    input  logic [`RV_XLEN-1:0]      s1_rs1_rdata_i,
    input  logic [`RV_XLEN-1:0]      s1_rs2_rdata_i,
    input  logic                     cf_req_i,
    input  logic [`RV_XLEN-1:0]      cf_target_i,
    input  logic                     cf_ack_i,
    output logic                     s2_valid_o,
    input  logic                     s2_busy_i,
    output rv_decode_pkg::dec_out_t  s2_out_o
);
    import rv_decode_pkg::*;

    dec_ctrl_t             ctrl;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   opr_a;
    logic [`RV_XLEN-1:0]   opr_b;
    logic [`RV_XLEN-1:0]   opr_c;
    logic                  accept;
    logic                  trap;
    trap_cause_e           cause;
    dec_out_t              n_out;

    assign s1_busy_o = s2_busy_i || s1_bubble_i;
    assign accept    = s1_valid_i && !s1_busy_o;

    rv_instr_classify u_classify (
        .s1_data_i  (s1_data_i),
        .ctrl_o     (ctrl),
        .rs1_addr_o (s1_rs1_addr_o),
        .rs2_addr_o (s1_rs2_addr_o),
        .rd_addr_o  (rd_addr)
    );

    rv_imm_gen u_imm_gen (
        .s1_data_i (s1_data_i),
        .imm_fmt_i (ctrl.imm_fmt),
        .imm_o     (imm)
    );

    rv_operand_select u_opr_sel (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .accept_i    (accept),
        .cf_req_i    (cf_req_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .src_i       (ctrl.opr_src),
        .imm_i       (imm),
        .rs1_rdata_i (s1_rs1_rdata_i),
        .rs2_rdata_i (s1_rs2_rdata_i),
        .opr_a_o     (opr_a),
        .opr_b_o     (opr_b),
        .opr_c_o     (opr_c)
    );

    // --------------------
    // Trap and result
    // --------------------

    assign trap  = s1_valid_i && (s1_error_i || ctrl.illegal);
    assign cause = ctrl.illegal ? TRAP_IOPCODE : TRAP_IACCESS;   // Illegal takes priority

    always_comb begin
        n_out.rd    = trap ? cause : (ctrl.opr_src.rd_none ? '0 : rd_addr);
        n_out.opr_a = opr_a;        // Kept on a fetch error
        n_out.opr_b = opr_b;
        n_out.opr_c = opr_c;
        n_out.uop   = trap ? '0 : ctrl.uop;
        n_out.fu    = trap ? FU_NONE : ctrl.fu;
        n_out.trap  = trap;
        n_out.instr = s1_data_i;
    end

    rv_decode_pipereg u_pipereg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .valid_i  (s1_valid_i),
        .bubble_i (s1_bubble_i),
        .flush_i  (s1_flush_i),
        .data_i   (n_out),
        .busy_i   (s2_busy_i),
        .valid_o  (s2_valid_o),
        .data_o   (s2_out_o)
    );

endmodule

`default_nettype wire

//--- src/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_imm_gen (
    input  logic [31:0]             s1_data_i,
    input  rv_decode_pkg::imm_fmt_e imm_fmt_i,
    output logic [`RV_XLEN-1:0]     imm_o
);
    import rv_decode_pkg::*;

    logic sign;                     // Instruction bit 31

    assign sign = s1_data_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_o = {{20{sign}}, s1_data_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, s1_data_i[31:25], s1_data_i[11:7]};
            IMM_B: begin
                imm_o = {{20{sign}}, s1_data_i[7], s1_data_i[30:25],
                         s1_data_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {s1_data_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{12{sign}}, s1_data_i[19:12], s1_data_i[20],
                         s1_data_i[30:21], 1'b0};
            end
            IMM_SHAMT: imm_o = {27'b0, s1_data_i[24:20]};   // Never sign-extended
            default:   imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/rv_instr_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_instr_classify (
    input  logic [31:0]              s1_data_i,
    output rv_decode_pkg::dec_ctrl_t ctrl_o,
    output logic [`RV_REG_AW-1:0]    rs1_addr_o,
    output logic [`RV_REG_AW-1:0]    rs2_addr_o,
    output logic [`RV_REG_AW-1:0]    rd_addr_o
);
    import rv_decode_pkg::*;

    // Major opcodes of RV32I, low two bits always 11
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    lsu_width_e width;
    lsu_uop_t   lsu;
    logic       known;              // Word is a supported encoding
    dec_ctrl_t  ctrl;

    assign opc    = opcode_e'(s1_data_i[6:0]);
    assign funct3 = s1_data_i[14:12];
    assign funct7 = s1_data_i[31:25];
    assign width  = funct3[1] ? LSU_WORD : (funct3[0] ? LSU_HALF : LSU_BYTE);

    always_comb begin
        ctrl  = '0;
        lsu   = '0;
        known = 1'b0;
        case (opc)
            OPC_LUI: begin
                known              = 1'b1;
                ctrl.fu            = FU_ALU;
                ctrl.uop           = ALU_OR;        // Zero OR immediate
                ctrl.imm_fmt       = IMM_U;
                ctrl.opr_src.b_imm = 1'b1;
            end
            OPC_AUIPC: begin
                known               = 1'b1;
                ctrl.fu             = FU_ALU;
                ctrl.uop            = ALU_ADD;
                ctrl.imm_fmt        = IMM_U;
                ctrl.opr_src.a_pcim = 1'b1;         // Sum formed here, B is zero
            end
            OPC_OP_IMM: begin
                known              = 1'b1;
                ctrl.fu            = FU_ALU;
                ctrl.imm_fmt       = IMM_I;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.uop = ALU_ADD;
                    3'b010: ctrl.uop = ALU_SLT;
                    3'b011: ctrl.uop = ALU_SLTU;
                    3'b100: ctrl.uop = ALU_XOR;
                    3'b110: ctrl.uop = ALU_OR;
                    3'b111: ctrl.uop = ALU_AND;
                    3'b001: begin
                        known        = (funct7 == 7'b0000000);
                        ctrl.uop     = ALU_SLL;
                        ctrl.imm_fmt = IMM_SHAMT;
                    end
                    default: begin
                        known        = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        ctrl.uop     = funct7[5] ? ALU_SRA : ALU_SRL;
                        ctrl.imm_fmt = IMM_SHAMT;
                    end
                endcase
            end
            OPC_OP: begin
                // Only add/sub and srl/sra use the alternate funct7
                known = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
                ctrl.fu            = FU_ALU;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctrl.uop = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.uop = ALU_SLL;
                    3'b010:  ctrl.uop = ALU_SLT;
                    3'b011:  ctrl.uop = ALU_SLTU;
                    3'b100:  ctrl.uop = ALU_XOR;
                    3'b101:  ctrl.uop = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl.uop = ALU_OR;
                    default: ctrl.uop = ALU_AND;
                endcase
            end
            OPC_LOAD: begin
                known              = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                lsu.load           = 1'b1;
                lsu.width          = width;
                lsu.is_signed      = !funct3[2];    // lb and lh
                ctrl.fu            = FU_LSU;
                ctrl.uop           = lsu;
                ctrl.imm_fmt       = IMM_I;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_imm = 1'b1;
            end
            OPC_STORE: begin
                known                = (funct3 < 3'b011);
                lsu.store            = 1'b1;
                lsu.width            = width;
                ctrl.fu              = FU_LSU;
                ctrl.uop             = lsu;
                ctrl.imm_fmt         = IMM_S;
                ctrl.opr_src.a_rs1   = 1'b1;
                ctrl.opr_src.b_imm   = 1'b1;
                ctrl.opr_src.c_rs2   = 1'b1;        // Store data
                ctrl.opr_src.rd_none = 1'b1;
            end
            OPC_BRANCH: begin
                known                = (funct3[2:1] != 2'b01);
                ctrl.fu              = FU_CFU;
                ctrl.imm_fmt         = IMM_B;
                ctrl.opr_src.a_rs1   = 1'b1;
                ctrl.opr_src.b_rs2   = 1'b1;
                ctrl.opr_src.c_pcim  = 1'b1;        // Branch target
                ctrl.opr_src.rd_none = 1'b1;
                case (funct3)
                    3'b000:  ctrl.uop = CFU_BEQ;
                    3'b001:  ctrl.uop = CFU_BNE;
                    3'b100:  ctrl.uop = CFU_BLT;
                    3'b101:  ctrl.uop = CFU_BGE;
                    3'b110:  ctrl.uop = CFU_BLTU;
                    default: ctrl.uop = CFU_BGEU;
                endcase
            end
            OPC_JAL: begin
                known               = 1'b1;
                ctrl.fu             = FU_CFU;
                ctrl.uop            = CFU_JALI;
                ctrl.imm_fmt        = IMM_J;
                ctrl.opr_src.c_pcim = 1'b1;
            end
            OPC_JALR: begin
                known              = (funct3 == 3'b000);
                ctrl.fu            = FU_CFU;
                ctrl.uop           = CFU_JALR;
                ctrl.imm_fmt       = IMM_I;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_imm = 1'b1;
            end
            OPC_SYSTEM: begin
                // Whole-word match, CSR accesses fall through as illegal
                ctrl.fu = FU_CFU;
                known   = 1'b1;
                case (s1_data_i)
                    32'h0000_0073: ctrl.uop = CFU_ECALL;
                    32'h0010_0073: ctrl.uop = CFU_EBREAK;
                    32'h3020_0073: ctrl.uop = CFU_MRET;
                    default:       known    = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    assign ctrl_o     = ctrl;
    assign rs1_addr_o = s1_data_i[19:15];
    assign rs2_addr_o = s1_data_i[24:20];
    assign rd_addr_o  = s1_data_i[11:7];

endmodule

`default_nettype wire

//--- src/rv_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_settings.svh"

module rv_operand_select (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    accept_i,
    input  logic                    cf_req_i,
    input  logic                    cf_ack_i,
    input  logic [`RV_XLEN-1:0]     cf_target_i,
    input  rv_decode_pkg::opr_src_t src_i,
    input  logic [`RV_XLEN-1:0]     imm_i,
    input  logic [`RV_XLEN-1:0]     rs1_rdata_i,
    input  logic [`RV_XLEN-1:0]     rs2_rdata_i,
    output logic [`RV_XLEN-1:0]     opr_a_o,
    output logic [`RV_XLEN-1:0]     opr_b_o,
    output logic [`RV_XLEN-1:0]     opr_c_o
);
    import rv_decode_pkg::*;

    localparam int XL = `RV_XLEN;

    opr_src_t        src;
    logic [XL-1:0]   pc_q;
    logic [XL-1:0]   pc_imm;       // PC-relative target

    assign src = src_i;

    // --------------------
    // Program counter
    // --------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `RV_PC_RESET;
        end else if (cf_req_i && cf_ack_i) begin
            pc_q <= cf_target_i;        // Redirect wins over advance
        end else if (accept_i) begin
            pc_q <= pc_q + XL'(4);
        end
    end

    assign pc_imm = pc_q + imm_i;

    // --------------------
    // Operand muxing
    // --------------------

    // Sources are one-hot per operand, so AND-OR is enough
    assign opr_a_o = ({XL{src.a_rs1}}  & rs1_rdata_i) |
                     ({XL{src.a_pcim}} & pc_imm);

    assign opr_b_o = ({XL{src.b_rs2}}  & rs2_rdata_i) |
                     ({XL{src.b_imm}}  & imm_i);

    assign opr_c_o = ({XL{src.c_rs2}}  & rs2_rdata_i) |
                     ({XL{src.c_pcim}} & pc_imm);

endmodule

`default_nettype wire
